//--- common/rvv_dispatch_pkg.sv
/*
 * localparams, vector typedefs and enums of the uop dispatch stage
 */
package rvv_dispatch_pkg;

    // vector register geometry
    localparam int VLEN            = 128;
    localparam int VLENB           = VLEN / 8;
    localparam int VLENB_WIDTH     = 4;

    // vl runs from 0 to VLEN, so one bit wider than an element index
    localparam int VL_WIDTH        = 8;
    localparam int VSTART_WIDTH    = 7;

    // up to 8 uops per instruction (LMUL 8)
    localparam int UOP_INDEX_WIDTH = 3;

    // element count and first active element
    typedef logic [VL_WIDTH-1:0]        vl_t;
    typedef logic [VSTART_WIDTH-1:0]    vstart_t;

    // uop position and uop count, the count is 1..8
    typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;
    typedef logic [UOP_INDEX_WIDTH:0]   uop_num_t;

    // v0 register and per-byte strobes
    typedef logic [VLEN-1:0]            mask_t;
    typedef logic [VLENB-1:0]           byte_strobe_t;

    // byte i sits in bits 2i+1:2i
    typedef logic [2*VLENB-1:0]         byte_type_vec_t;

    // effective element width of an operand
    typedef enum logic [2:0] {
        EEW_NONE,
        EEW1,
        EEW8,
        EEW16,
        EEW32
    } eew_e;

    // how a byte of an operand is treated by the execution side
    typedef enum logic [1:0] {
        BODY_ACTIVE,
        BODY_INACTIVE,
        TAIL,
        NOT_CHANGE
    } byte_type_e;

    // RDT is the reduction unit
    typedef enum logic {
        ALU,
        RDT
    } exe_unit_e;

    typedef enum logic {
        IDLE,
        ISSUE
    } dispatch_state_e;

endpackage

//--- dispatch/rvv_dispatch_ctrl.sv
/*
 * issue FSM of the dispatch stage
 * holds the accepted instruction and v0 until its last uop is handed off
 */
`timescale 1ns/1ps

module rvv_dispatch_ctrl
    import rvv_dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_valid,
    output logic       inst_ready,
    input  eew_e       inst_vs1_eew,
    input  eew_e       inst_vs2_eew,
    input  eew_e       inst_vd_eew,
    input  vl_t        inst_vl,
    input  vstart_t    inst_vstart,
    input  logic       inst_vm,
    input  logic       inst_ignore_vta,
    input  logic       inst_ignore_vma,
    input  exe_unit_e  inst_exe_unit,
    input  uop_num_t   inst_uop_num,
    input  mask_t      inst_v0,
    output logic       issue_valid,
    input  logic       issue_ready,
    input  logic       uop_last,
    output logic       load,
    output logic       advance,
    output eew_e       vs1_eew,
    output eew_e       vs2_eew,
    output eew_e       vd_eew,
    output vl_t        vl,
    output vstart_t    vstart,
    output logic       vm,
    output logic       ignore_vta,
    output logic       ignore_vma,
    output exe_unit_e  exe_unit,
    output uop_num_t   uop_num,
    output mask_t      v0
);

    dispatch_state_e state;
    dispatch_state_e state_nxt;

    assign inst_ready  = (state == IDLE);
    assign issue_valid = (state == ISSUE);

    // acceptance and handoff pulses for the counter
    assign load    = inst_valid && inst_ready;
    assign advance = issue_valid && issue_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (load)
                    state_nxt = ISSUE;
            end
            ISSUE: begin
                // back to idle once the last uop leaves
                if (advance && uop_last)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // instruction fields held for the whole uop sequence
    always_ff @(posedge clk) begin
        if (load) begin
            vs1_eew    <= inst_vs1_eew;
            vs2_eew    <= inst_vs2_eew;
            vd_eew     <= inst_vd_eew;
            vl         <= inst_vl;
            vstart     <= inst_vstart;
            vm         <= inst_vm;
            ignore_vta <= inst_ignore_vta;
            ignore_vma <= inst_ignore_vma;
            exe_unit   <= inst_exe_unit;
            uop_num    <= inst_uop_num;
            v0         <= inst_v0;
        end
    end

    // a count of 0 or above 8 never raises uop_last and would hold ISSUE forever
    a_uop_num_legal: assert property (@(posedge clk) disable iff (!arst_n)
        load |-> (inst_uop_num != '0) && (inst_uop_num <= uop_num_t'(8)));

endmodule

//--- dispatch/rvv_uop_counter.sv
/*
 * uop index counter with load, advance and last flag
 */
`timescale 1ns/1ps

module rvv_uop_counter
    import rvv_dispatch_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       load,
    input  logic       advance,
    input  uop_num_t   uop_num,
    output uop_index_t uop_index,
    output logic       uop_last
);

    // last uop of the instruction
    assign uop_last = ({1'b0, uop_index} == uop_num - 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uop_index <= '0;
        end else if (load) begin
            uop_index <= '0;
        end else if (advance && !uop_last) begin
            // hold on the last uop, the next load restarts at 0
            uop_index <= uop_index + 1'b1;
        end
    end

    // index stays inside the uop count across handoffs
    a_index_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        advance |=> ({1'b0, uop_index} < uop_num));

endmodule

//--- dispatch/rvv_opr_byte_type.sv
/*
 * byte-type classifier for vs1, vs2 and vd of one uop
 * also builds the v0 byte strobe for vd
 */
`timescale 1ns/1ps

module rvv_opr_byte_type
    import rvv_dispatch_pkg::*;
(
    input  eew_e           vs1_eew,
    input  eew_e           vs2_eew,
    input  eew_e           vd_eew,
    input  vl_t            vl,
    input  vstart_t        vstart,
    input  logic           vm,
    input  logic           ignore_vta,
    input  logic           ignore_vma,
    input  exe_unit_e      exe_unit,
    input  uop_index_t     uop_index,
    input  mask_t          v0,
    output byte_type_vec_t vs1_byte_type,
    output byte_type_vec_t vs2_byte_type,
    output byte_type_vec_t vd_byte_type,
    output byte_strobe_t   v0_strobe
);

    // log2 of the element size in bytes
    function automatic logic [1:0] eew_shift(input eew_e eew);
        case (eew)
            EEW16:   return 2'd1;
            EEW32:   return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    // first element of an operand, scaled down from the widest eew
    function automatic vl_t start_elem(input uop_index_t idx, input logic [1:0] max_shift,
                                       input logic [1:0] opr_shift);
        vl_t base;
        base = vl_t'(idx) >> (max_shift - opr_shift);
        return base << (VLENB_WIDTH - opr_shift);
    endfunction

    // source operand rule, enable already folds in vm and v0
    function automatic byte_type_e classify(input vl_t ele, input vl_t vl_in,
                                            input vstart_t vstart_in, input logic ign_vta,
                                            input logic ign_vma, input logic enable);
        if (ign_vta && ign_vma)
            return BODY_ACTIVE;
        else if (ele >= vl_in)
            return TAIL;
        else if (ele < {1'b0, vstart_in})
            return NOT_CHANGE;
        else if (enable || ign_vma)
            return BODY_ACTIVE;
        else
            return BODY_INACTIVE;
    endfunction

    eew_e       eew_max;
    logic [1:0] max_shift;
    logic [1:0] vs1_shift;
    logic [1:0] vs2_shift;
    logic [1:0] vd_shift;
    vl_t        vs1_start;
    vl_t        vs2_start;
    vl_t        vd_start;
    vl_t        vd_end;
    uop_index_t vd_part;

    always_comb begin
        if (vs1_eew == EEW32 || vs2_eew == EEW32 || vd_eew == EEW32)
            eew_max = EEW32;
        else if (vs1_eew == EEW16 || vs2_eew == EEW16 || vd_eew == EEW16)
            eew_max = EEW16;
        else if (vs1_eew == EEW8 || vs2_eew == EEW8 || vd_eew == EEW8)
            eew_max = EEW8;
        else if (vs1_eew == EEW1 || vs2_eew == EEW1 || vd_eew == EEW1)
            eew_max = EEW1;
        else
            eew_max = EEW_NONE;
    end

    assign max_shift = eew_shift(eew_max);
    assign vs1_shift = eew_shift(vs1_eew);
    assign vs2_shift = eew_shift(vs2_eew);
    assign vd_shift  = eew_shift(vd_eew);

    assign vs1_start = start_elem(uop_index, max_shift, vs1_shift);
    assign vd_start  = start_elem(uop_index, max_shift, vd_shift);

    // reduction walks vs2 one full register per uop
    assign vs2_start = (exe_unit == RDT) ? start_elem(uop_index, vs2_shift, vs2_shift)
                                         : start_elem(uop_index, max_shift, vs2_shift);

    // narrowing: later uops of a group cover more of vd
    assign vd_part = uop_index & uop_index_t'((1 << (max_shift - vd_shift)) - 1);
    assign vd_end  = vd_start + (vl_t'(vd_part) + 1'b1) * (vl_t'(VLENB) >> max_shift) - 1'b1;

    for (genvar i = 0; i < VLENB; i++) begin : gen_byte
        vl_t        vs1_ele;
        vl_t        vs2_ele;
        vl_t        vd_ele;
        logic       vd_enable;
        logic       strobe;
        byte_type_e vs1_type;
        byte_type_e vs2_type;
        byte_type_e vd_type;

        // element that byte i belongs to
        assign vs1_ele = vs1_start + (vl_t'(i) >> vs1_shift);
        assign vs2_ele = vs2_start + (vl_t'(i) >> vs2_shift);
        assign vd_ele  = vd_start + (vl_t'(i) >> vd_shift);

        assign vs1_type = classify(vs1_ele, vl, vstart, ignore_vta, ignore_vma,
                                   vm || v0[vs1_ele[VSTART_WIDTH-1:0]]);
        assign vs2_type = classify(vs2_ele, vl, vstart, ignore_vta, ignore_vma,
                                   vm || v0[vs2_ele[VSTART_WIDTH-1:0]]);

        assign vd_enable = vm || ignore_vma || v0[vd_ele[VSTART_WIDTH-1:0]];

        always_comb begin
            strobe = 1'b0;
            if (exe_unit == RDT) begin
                // scalar result in element 0 of vd
                case (vd_eew)
                    EEW32:   vd_type = (i < 4) ? BODY_ACTIVE : TAIL;
                    EEW16:   vd_type = (i < 2) ? BODY_ACTIVE : TAIL;
                    default: vd_type = (i < 1) ? BODY_ACTIVE : TAIL;
                endcase
            end else if (ignore_vta && ignore_vma) begin
                vd_type = BODY_ACTIVE;
            end else if (vd_ele >= vl) begin
                vd_type = TAIL;
            end else if (vd_ele < {1'b0, vstart}) begin
                vd_type = NOT_CHANGE;
            end else if (vd_ele > vd_end) begin
                // not written by this uop of a narrowing group
                vd_type = BODY_INACTIVE;
            end else begin
                vd_type = vd_enable ? BODY_ACTIVE : BODY_INACTIVE;
                strobe  = vd_enable;
            end
        end

        assign vs1_byte_type[2*i +: 2] = vs1_type;
        assign vs2_byte_type[2*i +: 2] = vs2_type;
        assign vd_byte_type[2*i +: 2]  = vd_type;
        assign v0_strobe[i]            = strobe;
    end

endmodule

//--- rtl/rvv_dispatch_reg.sv
/*
 * one-entry output register for classified uops, valid/ready
 */
`timescale 1ns/1ps

module rvv_dispatch_reg
    import rvv_dispatch_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           issue_valid,
    output logic           issue_ready,
    input  uop_index_t     issue_uop_index,
    input  logic           issue_uop_last,
    input  byte_type_vec_t issue_vs1_byte_type,
    input  byte_type_vec_t issue_vs2_byte_type,
    input  byte_type_vec_t issue_vd_byte_type,
    input  byte_strobe_t   issue_v0_strobe,
    output logic           uop_valid,
    input  logic           uop_ready,
    output uop_index_t     uop_index,
    output logic           uop_last,
    output byte_type_vec_t vs1_byte_type,
    output byte_type_vec_t vs2_byte_type,
    output byte_type_vec_t vd_byte_type,
    output byte_strobe_t   v0_strobe
);

    // accept when empty or when the current uop leaves this cycle
    assign issue_ready = !uop_valid || uop_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            uop_valid <= 1'b0;
        else if (issue_ready)
            uop_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            uop_index     <= issue_uop_index;
            uop_last      <= issue_uop_last;
            vs1_byte_type <= issue_vs1_byte_type;
            vs2_byte_type <= issue_vs2_byte_type;
            vd_byte_type  <= issue_vd_byte_type;
            v0_strobe     <= issue_v0_strobe;
        end
    end

    // stalled uop is held unchanged
    a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
        uop_valid && !uop_ready |=> uop_valid && $stable(uop_index) && $stable(uop_last)
            && $stable(vs1_byte_type) && $stable(vs2_byte_type)
            && $stable(vd_byte_type) && $stable(v0_strobe));

endmodule

//--- rtl/rvv_dispatch_top.sv
/*
 * uop dispatch stage top: controller, counter, classifier, output register
 */
`timescale 1ns/1ps

module rvv_dispatch_top
    import rvv_dispatch_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           inst_valid,
    output logic           inst_ready,
    input  eew_e           inst_vs1_eew,
    input  eew_e           inst_vs2_eew,
    input  eew_e           inst_vd_eew,
    input  vl_t            inst_vl,
    input  vstart_t        inst_vstart,
    input  logic           inst_vm,
    input  logic           inst_ignore_vta,
    input  logic           inst_ignore_vma,
    input  exe_unit_e      inst_exe_unit,
    input  uop_num_t       inst_uop_num,
    input  mask_t          inst_v0,
    output logic           uop_valid,
    input  logic           uop_ready,
    output uop_index_t     uop_index,
    output byte_type_vec_t vs1_byte_type,
    output byte_type_vec_t vs2_byte_type,
    output byte_type_vec_t vd_byte_type,
    output byte_strobe_t   v0_strobe,
    output logic           uop_last
);

    // held instruction
    eew_e           vs1_eew;
    eew_e           vs2_eew;
    eew_e           vd_eew;
    vl_t            vl;
    vstart_t        vstart;
    logic           vm;
    logic           ignore_vta;
    logic           ignore_vma;
    exe_unit_e      exe_unit;
    uop_num_t       uop_num;
    mask_t          v0;

    // issue side
    logic           issue_valid;
    logic           issue_ready;
    logic           load;
    logic           advance;
    uop_index_t     cnt_uop_index;
    logic           cnt_uop_last;
    byte_type_vec_t cls_vs1_byte_type;
    byte_type_vec_t cls_vs2_byte_type;
    byte_type_vec_t cls_vd_byte_type;
    byte_strobe_t   cls_v0_strobe;

    rvv_dispatch_ctrl u_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .inst_vs1_eew    (inst_vs1_eew),
        .inst_vs2_eew    (inst_vs2_eew),
        .inst_vd_eew     (inst_vd_eew),
        .inst_vl         (inst_vl),
        .inst_vstart     (inst_vstart),
        .inst_vm         (inst_vm),
        .inst_ignore_vta (inst_ignore_vta),
        .inst_ignore_vma (inst_ignore_vma),
        .inst_exe_unit   (inst_exe_unit),
        .inst_uop_num    (inst_uop_num),
        .inst_v0         (inst_v0),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .uop_last        (cnt_uop_last),
        .load            (load),
        .advance         (advance),
        .vs1_eew         (vs1_eew),
        .vs2_eew         (vs2_eew),
        .vd_eew          (vd_eew),
        .vl              (vl),
        .vstart          (vstart),
        .vm              (vm),
        .ignore_vta      (ignore_vta),
        .ignore_vma      (ignore_vma),
        .exe_unit        (exe_unit),
        .uop_num         (uop_num),
        .v0              (v0)
    );

    rvv_uop_counter u_counter (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (load),
        .advance   (advance),
        .uop_num   (uop_num),
        .uop_index (cnt_uop_index),
        .uop_last  (cnt_uop_last)
    );

    rvv_opr_byte_type u_byte_type (
        .vs1_eew       (vs1_eew),
        .vs2_eew       (vs2_eew),
        .vd_eew        (vd_eew),
        .vl            (vl),
        .vstart        (vstart),
        .vm            (vm),
        .ignore_vta    (ignore_vta),
        .ignore_vma    (ignore_vma),
        .exe_unit      (exe_unit),
        .uop_index     (cnt_uop_index),
        .v0            (v0),
        .vs1_byte_type (cls_vs1_byte_type),
        .vs2_byte_type (cls_vs2_byte_type),
        .vd_byte_type  (cls_vd_byte_type),
        .v0_strobe     (cls_v0_strobe)
    );

    rvv_dispatch_reg u_out_reg (
        .clk                 (clk),
        .arst_n              (arst_n),
        .issue_valid         (issue_valid),
        .issue_ready         (issue_ready),
        .issue_uop_index     (cnt_uop_index),
        .issue_uop_last      (cnt_uop_last),
        .issue_vs1_byte_type (cls_vs1_byte_type),
        .issue_vs2_byte_type (cls_vs2_byte_type),
        .issue_vd_byte_type  (cls_vd_byte_type),
        .issue_v0_strobe     (cls_v0_strobe),
        .uop_valid           (uop_valid),
        .uop_ready           (uop_ready),
        .uop_index           (uop_index),
        .uop_last            (uop_last),
        .vs1_byte_type       (vs1_byte_type),
        .vs2_byte_type       (vs2_byte_type),
        .vd_byte_type        (vd_byte_type),
        .v0_strobe           (v0_strobe)
    );

endmodule

//--- test/rvv_dispatch_model.svh
/*
 * instruction row type, stimulus table and reference byte classification
 */
`ifndef RVV_DISPATCH_MODEL_SVH
`define RVV_DISPATCH_MODEL_SVH

typedef struct {
    eew_e      vs1_eew;
    eew_e      vs2_eew;
    eew_e      vd_eew;
    vl_t       vl;
    vstart_t   vstart;
    logic      vm;
    logic      ignore_vta;
    logic      ignore_vma;
    exe_unit_e exe_unit;
    uop_num_t  uop_num;
    mask_t     v0;
} inst_row_t;

inst_row_t rows[$];

function automatic int eew_bytes(input eew_e eew);
    case (eew)
        EEW16:   return 2;
        EEW32:   return 4;
        default: return 1;
    endcase
endfunction

function automatic int widest_bytes(input inst_row_t r);
    int m;
    m = eew_bytes(r.vs1_eew);
    if (eew_bytes(r.vs2_eew) > m)
        m = eew_bytes(r.vs2_eew);
    if (eew_bytes(r.vd_eew) > m)
        m = eew_bytes(r.vd_eew);
    return m;
endfunction

// first element of an operand in uop idx
function automatic int first_elem(input inst_row_t r, input eew_e eew, input int idx);
    int ratio;
    ratio = widest_bytes(r) / eew_bytes(eew);
    return (idx / ratio) * (VLENB / eew_bytes(eew));
endfunction

// reduction reads a whole vs2 register per uop
function automatic int vs2_first_elem(input inst_row_t r, input int idx);
    if (r.exe_unit == RDT)
        return idx * (VLENB / eew_bytes(r.vs2_eew));
    return first_elem(r, r.vs2_eew, idx);
endfunction

function automatic byte_type_e rule_type(input inst_row_t r, input int ele);
    if (r.ignore_vta && r.ignore_vma)
        return BODY_ACTIVE;
    if (ele >= r.vl)
        return TAIL;
    if (ele < r.vstart)
        return NOT_CHANGE;
    if (r.vm || r.ignore_vma || r.v0[ele])
        return BODY_ACTIVE;
    return BODY_INACTIVE;
endfunction

function automatic byte_type_vec_t src_types(input inst_row_t r, input eew_e eew,
                                             input int start);
    byte_type_vec_t t;
    int i;
    for (i = 0; i < VLENB; i++)
        t[2*i +: 2] = rule_type(r, start + i / eew_bytes(eew));
    return t;
endfunction

function automatic void vd_expect(input inst_row_t r, input int idx,
                                  output byte_type_vec_t t, output byte_strobe_t s);
    int bytes;
    int ratio;
    int start;
    int vd_end;
    int ele;
    int i;
    logic both;
    byte_type_e bt;
    bytes = eew_bytes(r.vd_eew);
    ratio = widest_bytes(r) / bytes;
    start = first_elem(r, r.vd_eew, idx);
    // narrowing uops cover a growing slice of vd
    vd_end = start + (idx % ratio + 1) * (VLENB / widest_bytes(r)) - 1;
    both = r.ignore_vta && r.ignore_vma;
    for (i = 0; i < VLENB; i++) begin
        ele = start + i / bytes;
        bt = rule_type(r, ele);
        if (r.exe_unit == RDT)
            bt = (i < bytes) ? BODY_ACTIVE : TAIL;
        else if (bt == BODY_ACTIVE && ele > vd_end && !both)
            bt = BODY_INACTIVE;
        t[2*i +: 2] = bt;
        s[i] = (r.exe_unit == ALU) && !both && (bt == BODY_ACTIVE);
    end
endfunction

// v0 fill that mixes bit position and pattern number
function automatic mask_t mask_pattern(input int k);
    mask_t m;
    int b;
    for (b = 0; b < VLEN; b++)
        m[b] = ((b * (k + 3) + k) % 5) < 2;
    return m;
endfunction

task automatic add_row(input eew_e vs1, input eew_e vs2, input eew_e vd, input int vl,
                       input int vstart, input bit vm, input bit vta, input bit vma,
                       input exe_unit_e unit, input int uops, input int pattern);
    inst_row_t r;
    r.vs1_eew    = vs1;
    r.vs2_eew    = vs2;
    r.vd_eew     = vd;
    r.vl         = vl_t'(vl);
    r.vstart     = vstart_t'(vstart);
    r.vm         = vm;
    r.ignore_vta = vta;
    r.ignore_vma = vma;
    r.exe_unit   = unit;
    r.uop_num    = uop_num_t'(uops);
    r.v0         = mask_pattern(pattern);
    rows.push_back(r);
endtask

task automatic fill_table();
    //      vs1    vs2    vd     vl   vst vm vta vma unit uops v0
    add_row(EEW8,  EEW8,  EEW8,  40,  5,  1, 0,  0,  ALU, 4,   0);
    add_row(EEW16, EEW16, EEW16, 20,  3,  1, 0,  0,  ALU, 3,   0);
    add_row(EEW32, EEW32, EEW32, 10,  0,  1, 0,  0,  ALU, 4,   0);
    add_row(EEW8,  EEW8,  EEW8,  30,  2,  0, 0,  0,  ALU, 2,   1);
    add_row(EEW16, EEW16, EEW16, 12,  1,  0, 0,  1,  ALU, 2,   2);
    add_row(EEW32, EEW32, EEW32, 3,   0,  0, 1,  1,  ALU, 2,   3);
    add_row(EEW32, EEW32, EEW32, 7,   2,  0, 1,  0,  ALU, 3,   4);
    // widening
    add_row(EEW8,  EEW8,  EEW16, 24,  1,  0, 0,  0,  ALU, 4,   5);
    add_row(EEW8,  EEW16, EEW16, 16,  0,  1, 0,  0,  ALU, 2,   6);
    // narrowing by 2 and by 4
    add_row(EEW16, EEW32, EEW16, 12,  2,  0, 0,  0,  ALU, 4,   7);
    add_row(EEW8,  EEW32, EEW8,  20,  0,  1, 0,  0,  ALU, 8,   8);
    // reductions
    add_row(EEW32, EEW32, EEW32, 10,  0,  0, 0,  0,  RDT, 3,   9);
    add_row(EEW16, EEW8,  EEW16, 40,  0,  1, 0,  0,  RDT, 3,   10);
    add_row(EEW8,  EEW8,  EEW8,  5,   0,  0, 0,  0,  RDT, 1,   11);
    add_row(EEW8,  EEW8,  EEW8,  128, 0,  1, 0,  0,  ALU, 8,   12);
endtask

`endif

//--- test/rvv_dispatch_tb.sv
/*
 * testbench for the uop dispatch stage
 * table rows run once without and once with random uop_ready stalls
 */
`timescale 1ns/1ps

module rvv_dispatch_tb
    import rvv_dispatch_pkg::*;
();

    logic           clk;
    logic           arst_n;
    logic           inst_valid;
    logic           inst_ready;
    eew_e           inst_vs1_eew;
    eew_e           inst_vs2_eew;
    eew_e           inst_vd_eew;
    vl_t            inst_vl;
    vstart_t        inst_vstart;
    logic           inst_vm;
    logic           inst_ignore_vta;
    logic           inst_ignore_vma;
    exe_unit_e      inst_exe_unit;
    uop_num_t       inst_uop_num;
    mask_t          inst_v0;
    logic           uop_valid;
    logic           uop_ready;
    uop_index_t     uop_index;
    byte_type_vec_t vs1_byte_type;
    byte_type_vec_t vs2_byte_type;
    byte_type_vec_t vd_byte_type;
    byte_strobe_t   v0_strobe;
    logic           uop_last;

    `include "rvv_dispatch_model.svh"

    rvv_dispatch_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_index(input string name, input uop_index_t got, input uop_index_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_types(input string name, input byte_type_vec_t got,
                               input byte_type_vec_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_strobe(input string name, input byte_strobe_t got,
                                input byte_strobe_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // payload of uop idx against the reference rules
    task automatic check_uop(input inst_row_t r, input int idx);
        byte_type_vec_t exp_vd;
        byte_strobe_t   exp_strobe;
        vd_expect(r, idx, exp_vd, exp_strobe);
        check_index("uop_index", uop_index, uop_index_t'(idx));
        check_bit("uop_last", uop_last, idx == r.uop_num - 1);
        check_types("vs1_byte_type", vs1_byte_type,
                    src_types(r, r.vs1_eew, first_elem(r, r.vs1_eew, idx)));
        check_types("vs2_byte_type", vs2_byte_type,
                    src_types(r, r.vs2_eew, vs2_first_elem(r, idx)));
        check_types("vd_byte_type", vd_byte_type, exp_vd);
        check_strobe("v0_strobe", v0_strobe, exp_strobe);
    endtask

    task automatic run_inst(input inst_row_t r, input bit stall);
        int wait_cnt;
        int received;
        int seen;
        wait_cnt = 0;
        while (!inst_ready) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 50)
                abort_run("timeout while waiting for inst_ready");
        end
        inst_vs1_eew    = r.vs1_eew;
        inst_vs2_eew    = r.vs2_eew;
        inst_vd_eew     = r.vd_eew;
        inst_vl         = r.vl;
        inst_vstart     = r.vstart;
        inst_vm         = r.vm;
        inst_ignore_vta = r.ignore_vta;
        inst_ignore_vma = r.ignore_vma;
        inst_exe_unit   = r.exe_unit;
        inst_uop_num    = r.uop_num;
        inst_v0         = r.v0;
        inst_valid      = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;

        // a stalled uop is checked again on every cycle it is held
        received = 0;
        wait_cnt = 0;
        while (received < r.uop_num) begin
            seen = received + (uop_valid ? 1 : 0);
            check_bit("inst_ready", inst_ready, seen == r.uop_num);
            if (uop_valid)
                check_uop(r, received);
            uop_ready = stall ? ($urandom_range(99) >= 40) : 1'b1;
            if (uop_valid && uop_ready)
                received++;
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 200)
                abort_run("timeout while waiting for uops to leave");
        end
        check_bit("uop_valid", uop_valid, 1'b0);
        // without back-pressure, one empty cycle then one uop per cycle
        if (!stall && wait_cnt != r.uop_num + 1)
            abort_run("uops did not leave one per cycle without back-pressure");
    endtask

    initial begin
        int pass;
        int k;
        void'($urandom(32'h81ad));
        arst_n          = 1'b0;
        inst_valid      = 1'b0;
        inst_vs1_eew    = EEW8;
        inst_vs2_eew    = EEW8;
        inst_vd_eew     = EEW8;
        inst_vl         = '0;
        inst_vstart     = '0;
        inst_vm         = 1'b1;
        inst_ignore_vta = 1'b0;
        inst_ignore_vma = 1'b0;
        inst_exe_unit   = ALU;
        inst_uop_num    = 4'd1;
        inst_v0         = '0;
        uop_ready       = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_bit("uop_valid", uop_valid, 1'b0);
        check_bit("inst_ready", inst_ready, 1'b1);

        fill_table();
        for (pass = 0; pass < 2; pass++) begin
            for (k = 0; k < rows.size(); k++)
                run_inst(rows[k], pass == 1);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- rvv_dispatch_top.f
+incdir+test
common/rvv_dispatch_pkg.sv
dispatch/rvv_dispatch_ctrl.sv
dispatch/rvv_uop_counter.sv
dispatch/rvv_opr_byte_type.sv
rtl/rvv_dispatch_reg.sv
rtl/rvv_dispatch_top.sv
test/rvv_dispatch_tb.sv
